// ==== tb.f ====
soc_bus_pkg.sv
soc_io_pkg.sv
icb_bus_ctrl.sv
icb_sram.sv
key_filter.sv
hdmi_src_select.sv
activity_led.sv
rst_ctrl.sv
soc_top.sv
tb_soc_top.sv

// ==== tb_soc_top.sv ====
`default_nettype none
`timescale 1ns/10ps

module tb_soc_top;

    localparam int RAND_CYCLES    = 2000;
    localparam int PLAN_CYCLES    = 4 * soc_bus_pkg::SRAM_DEPTH + RAND_CYCLES + 400;
    localparam int TIMEOUT_CYCLES = 4 * PLAN_CYCLES;
    localparam int KEY_DB         = soc_io_pkg::DEBOUNCE_CYCLES;
    localparam int VID_W          = 3 + 3 * soc_io_pkg::PIX_W;
    localparam int DW             = soc_bus_pkg::DATA_W;

    logic clk;
    logic rst_n;
    logic i_soft_rst_req, i_dbg_rst_req, i_retire, i_key_dso_la;
    logic o_core_rst_n, o_core_active;
    logic i_m0_cmd_valid, i_m0_cmd_read, i_m0_rsp_ready;
    logic i_m1_cmd_valid, i_m1_cmd_read, i_m1_rsp_ready;
    logic [soc_bus_pkg::ADDR_W-1:0] i_m0_cmd_addr, i_m1_cmd_addr;
    logic [DW-1:0]                  i_m0_cmd_wdata, i_m1_cmd_wdata;
    logic [soc_bus_pkg::MASK_W-1:0] i_m0_cmd_wmask, i_m1_cmd_wmask;
    logic o_m0_cmd_ready, o_m0_rsp_valid, o_m0_rsp_err;
    logic o_m1_cmd_ready, o_m1_rsp_valid, o_m1_rsp_err;
    logic [DW-1:0] o_m0_rsp_rdata, o_m1_rsp_rdata;
    logic i_dso_vs, i_dso_hs, i_dso_de, i_la_vs, i_la_hs, i_la_de, o_vs, o_hs, o_de;
    logic [soc_io_pkg::PIX_W-1:0] i_dso_r, i_dso_g, i_dso_b, i_la_r, i_la_g, i_la_b;
    logic [soc_io_pkg::PIX_W-1:0] o_r, o_g, o_b;

    // reference model state
    logic [DW-1:0]                  mem_model [soc_bus_pkg::SRAM_DEPTH];
    logic                           hold [2];
    logic                           c_read [2];
    logic [soc_bus_pkg::ADDR_W-1:0] c_addr [2];
    logic [DW-1:0]                  c_wdata [2];
    logic [soc_bus_pkg::MASK_W-1:0] c_wmask [2];
    logic          pending, pend_m, pend_err, pend_read;
    logic [DW-1:0] pend_rdata;
    logic          exp_dso, exp_active, key_lvl, retire_on;
    int            blink_cnt;
    int            rst_hold;
    int            cycle_cnt = 0;

    soc_top u_dut (.*);

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt == TIMEOUT_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("SIMULATION FAILED");
            $fatal(1, "timeout");
        end
    end

    // **********************************************************************
    // helpers
    // **********************************************************************

    task automatic check_eq(input string what, input logic [DW-1:0] got,
                            input logic [DW-1:0] exp);
        if (got !== exp) begin
            $display("error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
            $display("SIMULATION FAILED");
            $fatal(1, "mismatch");
        end
    endtask

    function automatic logic [DW-1:0] merge_bytes(input logic [DW-1:0] old,
            input logic [DW-1:0] wdata, input logic [soc_bus_pkg::MASK_W-1:0] mask);
        logic [DW-1:0] res;
        int            b;
        res = old;
        for (b = 0; b < soc_bus_pkg::MASK_W; b++) begin
            if (mask[b]) begin
                res[8*b +: 8] = wdata[8*b +: 8];
            end
        end
        return res;
    endfunction

    // fill data mixes every index bit into every byte lane
    function automatic logic [DW-1:0] fill_word(input int i);
        return {i[7:0] ^ 8'h5a, ~i[7:0], 8'(i * 37), i[7:0]};
    endfunction

    function automatic logic [soc_bus_pkg::ADDR_W-1:0] sram_addr(input int i);
        logic [soc_bus_pkg::ADDR_W-1:0] a;
        a = '0;
        a[soc_bus_pkg::REGION_MSB:soc_bus_pkg::REGION_LSB] = soc_bus_pkg::SRAM_REGION;
        a[soc_bus_pkg::SRAM_AW+1:2] = soc_bus_pkg::SRAM_AW'(i);
        return a;
    endfunction

    task automatic load_cmd(input int m, input logic [soc_bus_pkg::ADDR_W-1:0] addr,
            input logic rd, input logic [DW-1:0] wdata,
            input logic [soc_bus_pkg::MASK_W-1:0] wmask);
        hold[m]    = 1'b1;
        c_addr[m]  = addr;
        c_read[m]  = rd;
        c_wdata[m] = wdata;
        c_wmask[m] = wmask;
    endtask

    // mostly sram hits, the rest lands in unmapped regions
    task automatic make_cmd(input int m);
        logic [soc_bus_pkg::ADDR_W-1:0] addr;
        addr = $urandom;
        addr[1:0] = 2'b00;
        if ($urandom_range(99) < 80) begin
            addr[soc_bus_pkg::REGION_MSB:soc_bus_pkg::REGION_LSB] = soc_bus_pkg::SRAM_REGION;
        end else if (addr[soc_bus_pkg::REGION_MSB:soc_bus_pkg::REGION_LSB]
                     == soc_bus_pkg::SRAM_REGION) begin
            addr[soc_bus_pkg::REGION_MSB:soc_bus_pkg::REGION_LSB] = '0;
        end
        load_cmd(m, addr, 1'($urandom_range(1, 0)), $urandom, 4'($urandom));
    endtask

    task automatic accept(input int m);
        logic [soc_bus_pkg::SRAM_AW-1:0] idx;
        idx        = c_addr[m][soc_bus_pkg::SRAM_AW+1:2];
        pending    = 1'b1;
        pend_m     = (m == 1);
        pend_read  = c_read[m];
        pend_err   = c_addr[m][soc_bus_pkg::REGION_MSB:soc_bus_pkg::REGION_LSB]
                     != soc_bus_pkg::SRAM_REGION;
        pend_rdata = '0;
        if (!pend_err && c_read[m]) begin
            pend_rdata = mem_model[idx];
        end else if (!pend_err) begin
            mem_model[idx] = merge_bytes(mem_model[idx], c_wdata[m], c_wmask[m]);
        end
        hold[m] = 1'b0;
    endtask

    // effect of the coming rising edge on the model
    task automatic predict();
        if (rst_hold > 0) begin
            rst_hold--;
        end else if (i_soft_rst_req || i_dbg_rst_req) begin
            rst_hold   = soc_io_pkg::RST_HOLD_CYCLES;
            pending    = 1'b0;
            exp_dso    = 1'b1;
            exp_active = 1'b1;
            blink_cnt  = 0;
        end else begin
            if (pending) begin
                if (pend_m ? i_m1_rsp_ready : i_m0_rsp_ready) begin
                    pending = 1'b0;
                end
            end else if (hold[0]) begin
                accept(0);
            end else if (hold[1]) begin
                accept(1);
            end
            if (i_retire) begin
                if (blink_cnt == soc_io_pkg::BLINK_COUNT) begin
                    blink_cnt  = 0;
                    exp_active = !exp_active;
                end else begin
                    blink_cnt++;
                end
            end
        end
    endtask

    task automatic check_outputs();
        logic [VID_W-1:0] exp_vid;
        check_eq("m0 cmd_ready", o_m0_cmd_ready, !pending);
        check_eq("m1 cmd_ready", o_m1_cmd_ready, !pending && !i_m0_cmd_valid);
        check_eq("m0 rsp_valid", o_m0_rsp_valid, pending && !pend_m);
        check_eq("m1 rsp_valid", o_m1_rsp_valid, pending && pend_m);
        if (pending) begin
            check_eq("rsp_err", pend_m ? o_m1_rsp_err : o_m0_rsp_err, pend_err);
            if (pend_err || pend_read) begin
                check_eq("rsp_rdata", pend_m ? o_m1_rsp_rdata : o_m0_rsp_rdata, pend_rdata);
            end
        end
        check_eq("core_rst_n", o_core_rst_n, rst_hold == 0);
        check_eq("core_active", o_core_active, exp_active);
        exp_vid = exp_dso ? {i_dso_vs, i_dso_hs, i_dso_de, i_dso_r, i_dso_g, i_dso_b}
                          : {i_la_vs, i_la_hs, i_la_de, i_la_r, i_la_g, i_la_b};
        check_eq("video out", {o_vs, o_hs, o_de, o_r, o_g, o_b}, exp_vid);
    endtask

    // one clock: check, then drive on the falling edge, then predict
    task automatic step(input bit traffic, input int rdy_pct, input int req);
        int m;
        @(negedge clk);
        check_outputs();
        {i_dso_vs, i_dso_hs, i_dso_de, i_dso_r, i_dso_g, i_dso_b} = VID_W'($urandom);
        {i_la_vs, i_la_hs, i_la_de, i_la_r, i_la_g, i_la_b}       = VID_W'($urandom);
        i_retire       = retire_on && ($urandom_range(1, 0) == 1);
        i_key_dso_la   = key_lvl;
        i_soft_rst_req = (req == 1);
        i_dbg_rst_req  = (req == 2);
        for (m = 0; m < 2; m++) begin
            if (traffic && !hold[m] && $urandom_range(99) < 40) begin
                make_cmd(m);
            end
        end
        i_m0_cmd_valid = hold[0];
        i_m0_cmd_addr  = c_addr[0];
        i_m0_cmd_read  = c_read[0];
        i_m0_cmd_wdata = c_wdata[0];
        i_m0_cmd_wmask = c_wmask[0];
        i_m1_cmd_valid = hold[1];
        i_m1_cmd_addr  = c_addr[1];
        i_m1_cmd_read  = c_read[1];
        i_m1_cmd_wdata = c_wdata[1];
        i_m1_cmd_wmask = c_wmask[1];
        i_m0_rsp_ready = $urandom_range(99) < rdy_pct;
        i_m1_rsp_ready = $urandom_range(99) < rdy_pct;
        predict();
    endtask

    task automatic issue(input int m, input logic [soc_bus_pkg::ADDR_W-1:0] addr,
            input logic rd, input logic [DW-1:0] wdata);
        while (hold[m]) begin
            step(0, 100, 0);
        end
        load_cmd(m, addr, rd, wdata, '1);
    endtask

    task automatic drain();
        while (hold[0] || hold[1] || pending) begin
            step(0, 100, 0);
        end
    endtask

    // **********************************************************************
    // test sequence
    // **********************************************************************

    initial begin
        void'($urandom(98));
        clk = 1'b0;
        rst_n = 1'b0;
        {i_soft_rst_req, i_dbg_rst_req, i_retire} = '0;
        i_key_dso_la = 1'b1;
        {i_m0_cmd_valid, i_m0_cmd_read, i_m0_rsp_ready, i_m0_cmd_addr} = '0;
        {i_m0_cmd_wdata, i_m0_cmd_wmask} = '0;
        {i_m1_cmd_valid, i_m1_cmd_read, i_m1_rsp_ready, i_m1_cmd_addr} = '0;
        {i_m1_cmd_wdata, i_m1_cmd_wmask} = '0;
        {i_dso_vs, i_dso_hs, i_dso_de, i_dso_r, i_dso_g, i_dso_b} = '0;
        {i_la_vs, i_la_hs, i_la_de, i_la_r, i_la_g, i_la_b} = '0;
        hold = '{2{1'b0}};
        c_read = '{2{1'b0}};
        c_addr = '{2{'0}};
        c_wdata = '{2{'0}};
        c_wmask = '{2{'0}};
        {pending, pend_m, pend_err, pend_read, pend_rdata} = '0;
        {exp_dso, exp_active, key_lvl, retire_on} = 4'b1110;
        blink_cnt = 0;
        rst_hold = 0;

        repeat (2) @(negedge clk);
        rst_n = 1'b1;
        while (!o_core_rst_n) @(negedge clk);

        // preload every sram word through the debug master
        for (int i = 0; i < soc_bus_pkg::SRAM_DEPTH; i++) begin
            issue(0, sram_addr(i), 1'b0, fill_word(i));
        end
        drain();

        retire_on = 1'b1;
        repeat (RAND_CYCLES) step(1, 70, 0);
        drain();

        // both masters at once, response held back by rsp_ready
        load_cmd(0, sram_addr(3), 1'b1, '0, '0);
        load_cmd(1, 32'h0000_0040, 1'b0, $urandom, '1);
        repeat (6) step(0, 0, 0);
        drain();

        // short glitch, no toggle expected
        key_lvl = 1'b0;
        repeat (KEY_DB - 1) step(0, 100, 0);
        key_lvl = 1'b1;
        repeat (KEY_DB + 4) step(0, 100, 0);

        // real press, pulse after KEY_DB+2 edges, source swaps on the next
        // keep holding so a second pulse would show
        key_lvl = 1'b0;
        step(0, 100, 0);
        for (int k = 1; k <= 4 * KEY_DB; k++) begin
            if (k == KEY_DB + 3) begin
                exp_dso = !exp_dso;
            end
            step(0, 100, 0);
        end
        key_lvl = 1'b1;
        repeat (KEY_DB + 4) step(0, 100, 0);

        while (exp_active) step(0, 100, 0);
        retire_on = 1'b0;
        step(0, 100, 1);
        repeat (soc_io_pkg::RST_HOLD_CYCLES + 3) step(0, 100, 0);
        step(0, 100, 2);
        repeat (soc_io_pkg::RST_HOLD_CYCLES + 3) step(0, 100, 0);

        // sram survives the soft resets
        for (int i = 0; i < soc_bus_pkg::SRAM_DEPTH; i++) begin
            issue(1, sram_addr(i), 1'b1, '0);
        end
        drain();
        step(0, 100, 0);

        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== soc_top.sv ====
`default_nettype none
`timescale 1ns/10ps

module soc_top (
    input  wire                            clk,
    input  wire                            rst_n,
    input  wire                            i_soft_rst_req,
    input  wire                            i_dbg_rst_req,
    input  wire                            i_retire,
    input  wire                            i_key_dso_la,
    output logic                           o_core_rst_n,
    output logic                           o_core_active,
    // m0, debug master
    input  wire                            i_m0_cmd_valid,
    output logic                           o_m0_cmd_ready,
    input  wire  [soc_bus_pkg::ADDR_W-1:0] i_m0_cmd_addr,
    input  wire                            i_m0_cmd_read,
    input  wire  [soc_bus_pkg::DATA_W-1:0] i_m0_cmd_wdata,
    input  wire  [soc_bus_pkg::MASK_W-1:0] i_m0_cmd_wmask,
    output logic                           o_m0_rsp_valid,
    input  wire                            i_m0_rsp_ready,
    output logic                           o_m0_rsp_err,
    output logic [soc_bus_pkg::DATA_W-1:0] o_m0_rsp_rdata,
    // m1, core master
    input  wire                            i_m1_cmd_valid,
    output logic                           o_m1_cmd_ready,
    input  wire  [soc_bus_pkg::ADDR_W-1:0] i_m1_cmd_addr,
    input  wire                            i_m1_cmd_read,
    input  wire  [soc_bus_pkg::DATA_W-1:0] i_m1_cmd_wdata,
    input  wire  [soc_bus_pkg::MASK_W-1:0] i_m1_cmd_wmask,
    output logic                           o_m1_rsp_valid,
    input  wire                            i_m1_rsp_ready,
    output logic                           o_m1_rsp_err,
    output logic [soc_bus_pkg::DATA_W-1:0] o_m1_rsp_rdata,
    // video sources
    input  wire                            i_dso_vs,
    input  wire                            i_dso_hs,
    input  wire                            i_dso_de,
    input  wire  [soc_io_pkg::PIX_W-1:0]   i_dso_r,
    input  wire  [soc_io_pkg::PIX_W-1:0]   i_dso_g,
    input  wire  [soc_io_pkg::PIX_W-1:0]   i_dso_b,
    input  wire                            i_la_vs,
    input  wire                            i_la_hs,
    input  wire                            i_la_de,
    input  wire  [soc_io_pkg::PIX_W-1:0]   i_la_r,
    input  wire  [soc_io_pkg::PIX_W-1:0]   i_la_g,
    input  wire  [soc_io_pkg::PIX_W-1:0]   i_la_b,
    // hdmi out
    output logic                           o_vs,
    output logic                           o_hs,
    output logic                           o_de,
    output logic [soc_io_pkg::PIX_W-1:0]   o_r,
    output logic [soc_io_pkg::PIX_W-1:0]   o_g,
    output logic [soc_io_pkg::PIX_W-1:0]   o_b
);

    logic                           sys_rst_n;
    logic                           key_flag;
    logic                           sram_cmd_valid;
    logic [soc_bus_pkg::ADDR_W-1:0] sram_cmd_addr;
    logic                           sram_cmd_read;
    logic [soc_bus_pkg::DATA_W-1:0] sram_cmd_wdata;
    logic [soc_bus_pkg::MASK_W-1:0] sram_cmd_wmask;
    logic                           sram_rsp_valid;
    logic [soc_bus_pkg::DATA_W-1:0] sram_rsp_rdata;

    // **********************************************************************
    // reset
    // **********************************************************************

    rst_ctrl u_rst_ctrl (
        .clk            (clk),
        .i_rst_n        (rst_n),
        .i_soft_rst_req (i_soft_rst_req),
        .i_dbg_rst_req  (i_dbg_rst_req),
        .o_rst_n        (sys_rst_n)
    );

    assign o_core_rst_n = sys_rst_n;

    // **********************************************************************
    // icb fabric
    // **********************************************************************

    icb_bus_ctrl u_icb_bus_ctrl (
        .clk              (clk),
        .rst_n            (sys_rst_n),
        .i_m0_cmd_valid   (i_m0_cmd_valid),
        .o_m0_cmd_ready   (o_m0_cmd_ready),
        .i_m0_cmd_addr    (i_m0_cmd_addr),
        .i_m0_cmd_read    (i_m0_cmd_read),
        .i_m0_cmd_wdata   (i_m0_cmd_wdata),
        .i_m0_cmd_wmask   (i_m0_cmd_wmask),
        .o_m0_rsp_valid   (o_m0_rsp_valid),
        .i_m0_rsp_ready   (i_m0_rsp_ready),
        .o_m0_rsp_err     (o_m0_rsp_err),
        .o_m0_rsp_rdata   (o_m0_rsp_rdata),
        .i_m1_cmd_valid   (i_m1_cmd_valid),
        .o_m1_cmd_ready   (o_m1_cmd_ready),
        .i_m1_cmd_addr    (i_m1_cmd_addr),
        .i_m1_cmd_read    (i_m1_cmd_read),
        .i_m1_cmd_wdata   (i_m1_cmd_wdata),
        .i_m1_cmd_wmask   (i_m1_cmd_wmask),
        .o_m1_rsp_valid   (o_m1_rsp_valid),
        .i_m1_rsp_ready   (i_m1_rsp_ready),
        .o_m1_rsp_err     (o_m1_rsp_err),
        .o_m1_rsp_rdata   (o_m1_rsp_rdata),
        .o_sram_cmd_valid (sram_cmd_valid),
        .o_sram_cmd_addr  (sram_cmd_addr),
        .o_sram_cmd_read  (sram_cmd_read),
        .o_sram_cmd_wdata (sram_cmd_wdata),
        .o_sram_cmd_wmask (sram_cmd_wmask),
        .i_sram_rsp_valid (sram_rsp_valid),
        .i_sram_rsp_rdata (sram_rsp_rdata)
    );

    icb_sram u_icb_sram (
        .clk         (clk),
        .rst_n       (sys_rst_n),
        .i_cmd_valid (sram_cmd_valid),
        .i_cmd_addr  (sram_cmd_addr),
        .i_cmd_read  (sram_cmd_read),
        .i_cmd_wdata (sram_cmd_wdata),
        .i_cmd_wmask (sram_cmd_wmask),
        .o_rsp_valid (sram_rsp_valid),
        .o_rsp_rdata (sram_rsp_rdata)
    );

    // **********************************************************************
    // board side
    // **********************************************************************

    key_filter u_key_filter (
        .clk        (clk),
        .rst_n      (sys_rst_n),
        .i_key      (i_key_dso_la),
        .o_key_flag (key_flag)
    );

    hdmi_src_select u_hdmi_src_select (
        .clk      (clk),
        .rst_n    (sys_rst_n),
        .i_toggle (key_flag),
        .i_dso_vs (i_dso_vs),
        .i_dso_hs (i_dso_hs),
        .i_dso_de (i_dso_de),
        .i_dso_r  (i_dso_r),
        .i_dso_g  (i_dso_g),
        .i_dso_b  (i_dso_b),
        .i_la_vs  (i_la_vs),
        .i_la_hs  (i_la_hs),
        .i_la_de  (i_la_de),
        .i_la_r   (i_la_r),
        .i_la_g   (i_la_g),
        .i_la_b   (i_la_b),
        .o_vs     (o_vs),
        .o_hs     (o_hs),
        .o_de     (o_de),
        .o_r      (o_r),
        .o_g      (o_g),
        .o_b      (o_b)
    );

    activity_led u_activity_led (
        .clk      (clk),
        .rst_n    (sys_rst_n),
        .i_retire (i_retire),
        .o_active (o_core_active)
    );

endmodule

`default_nettype wire

// ==== rst_ctrl.sv ====
`default_nettype none
`timescale 1ns/10ps

module rst_ctrl (
    input  wire  clk,
    input  wire  i_rst_n,
    input  wire  i_soft_rst_req,
    input  wire  i_dbg_rst_req,
    output logic o_rst_n
);

    localparam int HOLD_W = $clog2(soc_io_pkg::RST_HOLD_CYCLES + 1);

    logic [soc_io_pkg::RST_SYNC_STAGES-1:0] rel_sync;
    logic [HOLD_W-1:0]                      hold_cnt;

    // assert at once, release through the synchroniser
    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            rel_sync <= '0;
        end else begin
            rel_sync <= {rel_sync[soc_io_pkg::RST_SYNC_STAGES-2:0], 1'b1};
        end
    end

    // soft or debug request, a new one restarts the hold
    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            hold_cnt <= '0;
        end else if (i_soft_rst_req || i_dbg_rst_req) begin
            hold_cnt <= HOLD_W'(soc_io_pkg::RST_HOLD_CYCLES);
        end else if (hold_cnt != '0) begin
            hold_cnt <= hold_cnt - 1'b1;
        end
    end

    assign o_rst_n = rel_sync[soc_io_pkg::RST_SYNC_STAGES-1] && (hold_cnt == '0);

    a_hold_len : assert property (@(posedge clk) disable iff (!i_rst_n)
        (i_soft_rst_req || i_dbg_rst_req) |=> !o_rst_n [*soc_io_pkg::RST_HOLD_CYCLES]);

endmodule

`default_nettype wire

// ==== activity_led.sv ====
`default_nettype none
`timescale 1ns/10ps

module activity_led (
    input  wire  clk,
    input  wire  rst_n,
    input  wire  i_retire,
    output logic o_active
);

    localparam int CNT_W = $clog2(soc_io_pkg::BLINK_COUNT + 1);

    logic [CNT_W-1:0] retire_cnt;

    // blinks as long as instructions keep retiring
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            retire_cnt <= '0;
            o_active   <= 1'b1;
        end else if (i_retire) begin
            if (retire_cnt == CNT_W'(soc_io_pkg::BLINK_COUNT)) begin
                retire_cnt <= '0;
                o_active   <= !o_active;
            end else begin
                retire_cnt <= retire_cnt + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== hdmi_src_select.sv ====
`default_nettype none
`timescale 1ns/10ps

module hdmi_src_select (
    input  wire                            clk,
    input  wire                            rst_n,
    input  wire                            i_toggle,
    input  wire                            i_dso_vs,
    input  wire                            i_dso_hs,
    input  wire                            i_dso_de,
    input  wire  [soc_io_pkg::PIX_W-1:0]   i_dso_r,
    input  wire  [soc_io_pkg::PIX_W-1:0]   i_dso_g,
    input  wire  [soc_io_pkg::PIX_W-1:0]   i_dso_b,
    input  wire                            i_la_vs,
    input  wire                            i_la_hs,
    input  wire                            i_la_de,
    input  wire  [soc_io_pkg::PIX_W-1:0]   i_la_r,
    input  wire  [soc_io_pkg::PIX_W-1:0]   i_la_g,
    input  wire  [soc_io_pkg::PIX_W-1:0]   i_la_b,
    output logic                           o_vs,
    output logic                           o_hs,
    output logic                           o_de,
    output logic [soc_io_pkg::PIX_W-1:0]   o_r,
    output logic [soc_io_pkg::PIX_W-1:0]   o_g,
    output logic [soc_io_pkg::PIX_W-1:0]   o_b
);

    logic dso_en;

    // dso after reset, each key press swaps
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dso_en <= 1'b1;
        end else if (i_toggle) begin
            dso_en <= !dso_en;
        end
    end

    assign o_vs = dso_en ? i_dso_vs : i_la_vs;
    assign o_hs = dso_en ? i_dso_hs : i_la_hs;
    assign o_de = dso_en ? i_dso_de : i_la_de;
    assign o_r  = dso_en ? i_dso_r  : i_la_r;
    assign o_g  = dso_en ? i_dso_g  : i_la_g;
    assign o_b  = dso_en ? i_dso_b  : i_la_b;

endmodule

`default_nettype wire

// ==== key_filter.sv ====
`default_nettype none
`timescale 1ns/10ps

module key_filter (
    input  wire  clk,
    input  wire  rst_n,
    input  wire  i_key,
    output logic o_key_flag
);

    localparam int CNT_W = $clog2(soc_io_pkg::DEBOUNCE_CYCLES + 1);

    logic             key_meta;
    logic             key_sync;
    logic [CNT_W-1:0] low_cnt;

    // two-flop synchroniser, key idles high
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            key_meta <= 1'b1;
            key_sync <= 1'b1;
        end else begin
            key_meta <= i_key;
            key_sync <= key_meta;
        end
    end

    // count stable low cycles, saturate so a held key fires once
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            low_cnt    <= '0;
            o_key_flag <= 1'b0;
        end else begin
            if (key_sync) begin
                low_cnt <= '0;
            end else if (low_cnt != CNT_W'(soc_io_pkg::DEBOUNCE_CYCLES)) begin
                low_cnt <= low_cnt + 1'b1;
            end
            o_key_flag <= !key_sync && (low_cnt == CNT_W'(soc_io_pkg::DEBOUNCE_CYCLES - 1));
        end
    end

endmodule

`default_nettype wire

// ==== icb_sram.sv ====
`default_nettype none
`timescale 1ns/10ps

module icb_sram (
    input  wire                             clk,
    input  wire                             rst_n,
    input  wire                             i_cmd_valid,
    input  wire  [soc_bus_pkg::ADDR_W-1:0]  i_cmd_addr,
    input  wire                             i_cmd_read,
    input  wire  [soc_bus_pkg::DATA_W-1:0]  i_cmd_wdata,
    input  wire  [soc_bus_pkg::MASK_W-1:0]  i_cmd_wmask,
    output logic                            o_rsp_valid,
    output logic [soc_bus_pkg::DATA_W-1:0]  o_rsp_rdata
);

    logic [soc_bus_pkg::DATA_W-1:0]  mem [soc_bus_pkg::SRAM_DEPTH];
    logic [soc_bus_pkg::SRAM_AW-1:0] word_addr;

    // word index sits just above the byte offset
    assign word_addr = i_cmd_addr[soc_bus_pkg::SRAM_AW+1:2];

    always_ff @(posedge clk) begin
        if (i_cmd_valid && !i_cmd_read) begin
            for (int b = 0; b < soc_bus_pkg::MASK_W; b++) begin
                if (i_cmd_wmask[b]) begin
                    mem[word_addr][8*b +: 8] <= i_cmd_wdata[8*b +: 8];
                end
            end
        end
        if (i_cmd_valid && i_cmd_read) begin
            o_rsp_rdata <= mem[word_addr];
        end
    end

    // always ready, answer comes one cycle later
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            o_rsp_valid <= 1'b0;
        end else begin
            o_rsp_valid <= i_cmd_valid;
        end
    end

    // fabric must not issue while the previous answer is on the bus
    a_no_overlap : assert property (@(posedge clk) disable iff (!rst_n)
        o_rsp_valid |-> !i_cmd_valid);

endmodule

`default_nettype wire

// ==== icb_bus_ctrl.sv ====
`default_nettype none
`timescale 1ns/10ps

module icb_bus_ctrl (
    input  wire                              clk,
    input  wire                              rst_n,
    // m0, debug master
    input  wire                              i_m0_cmd_valid,
    output logic                             o_m0_cmd_ready,
    input  wire  [soc_bus_pkg::ADDR_W-1:0]   i_m0_cmd_addr,
    input  wire                              i_m0_cmd_read,
    input  wire  [soc_bus_pkg::DATA_W-1:0]   i_m0_cmd_wdata,
    input  wire  [soc_bus_pkg::MASK_W-1:0]   i_m0_cmd_wmask,
    output logic                             o_m0_rsp_valid,
    input  wire                              i_m0_rsp_ready,
    output logic                             o_m0_rsp_err,
    output logic [soc_bus_pkg::DATA_W-1:0]   o_m0_rsp_rdata,
    // m1, core master
    input  wire                              i_m1_cmd_valid,
    output logic                             o_m1_cmd_ready,
    input  wire  [soc_bus_pkg::ADDR_W-1:0]   i_m1_cmd_addr,
    input  wire                              i_m1_cmd_read,
    input  wire  [soc_bus_pkg::DATA_W-1:0]   i_m1_cmd_wdata,
    input  wire  [soc_bus_pkg::MASK_W-1:0]   i_m1_cmd_wmask,
    output logic                             o_m1_rsp_valid,
    input  wire                              i_m1_rsp_ready,
    output logic                             o_m1_rsp_err,
    output logic [soc_bus_pkg::DATA_W-1:0]   o_m1_rsp_rdata,
    // sram slave
    output logic                             o_sram_cmd_valid,
    output logic [soc_bus_pkg::ADDR_W-1:0]   o_sram_cmd_addr,
    output logic                             o_sram_cmd_read,
    output logic [soc_bus_pkg::DATA_W-1:0]   o_sram_cmd_wdata,
    output logic [soc_bus_pkg::MASK_W-1:0]   o_sram_cmd_wmask,
    input  wire                              i_sram_rsp_valid,
    input  wire  [soc_bus_pkg::DATA_W-1:0]   i_sram_rsp_rdata
);

    logic                           pick_m1;
    logic                           cmd_accept;
    logic                           sram_hit;
    logic                           rsp_pending;
    logic                           rsp_fire;
    logic                           grant_m1_q;
    soc_bus_pkg::slave_sel_t        sel_q;
    logic [soc_bus_pkg::DATA_W-1:0] rdata_q;
    logic [soc_bus_pkg::DATA_W-1:0] rsp_rdata;

    // **********************************************************************
    // arbitration and decode
    // **********************************************************************

    // m0 has fixed priority
    assign pick_m1        = !i_m0_cmd_valid;
    assign o_m0_cmd_ready = !rsp_pending;
    assign o_m1_cmd_ready = !rsp_pending && pick_m1;
    assign cmd_accept     = !rsp_pending && (i_m0_cmd_valid || i_m1_cmd_valid);

    assign o_sram_cmd_addr  = pick_m1 ? i_m1_cmd_addr  : i_m0_cmd_addr;
    assign o_sram_cmd_read  = pick_m1 ? i_m1_cmd_read  : i_m0_cmd_read;
    assign o_sram_cmd_wdata = pick_m1 ? i_m1_cmd_wdata : i_m0_cmd_wdata;
    assign o_sram_cmd_wmask = pick_m1 ? i_m1_cmd_wmask : i_m0_cmd_wmask;

    assign sram_hit = o_sram_cmd_addr[soc_bus_pkg::REGION_MSB:soc_bus_pkg::REGION_LSB]
                      == soc_bus_pkg::SRAM_REGION;
    assign o_sram_cmd_valid = cmd_accept && sram_hit;

    // **********************************************************************
    // response path
    // **********************************************************************

    assign rsp_fire = rsp_pending && (grant_m1_q ? i_m1_rsp_ready : i_m0_rsp_ready);

    // one transaction in flight, remember who asked and where it went
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rsp_pending <= 1'b0;
            grant_m1_q  <= 1'b0;
            sel_q       <= soc_bus_pkg::SEL_SRAM;
        end else if (cmd_accept) begin
            rsp_pending <= 1'b1;
            grant_m1_q  <= pick_m1;
            sel_q       <= sram_hit ? soc_bus_pkg::SEL_SRAM : soc_bus_pkg::SEL_ERR;
        end else if (rsp_fire) begin
            rsp_pending <= 1'b0;
        end
    end

    // sram flags its data for one cycle only, keep it for a stalled master
    always_ff @(posedge clk) begin
        if (i_sram_rsp_valid) begin
            rdata_q <= i_sram_rsp_rdata;
        end
    end

    // error responder returns zero data
    assign rsp_rdata = (sel_q == soc_bus_pkg::SEL_ERR) ? '0 :
                       (i_sram_rsp_valid ? i_sram_rsp_rdata : rdata_q);

    assign o_m0_rsp_valid = rsp_pending && !grant_m1_q;
    assign o_m1_rsp_valid = rsp_pending && grant_m1_q;
    assign o_m0_rsp_err   = (sel_q == soc_bus_pkg::SEL_ERR);
    assign o_m1_rsp_err   = (sel_q == soc_bus_pkg::SEL_ERR);
    assign o_m0_rsp_rdata = rsp_rdata;
    assign o_m1_rsp_rdata = rsp_rdata;

    // stalled response holds its target, kind and data
    a_rsp_stable : assert property (@(posedge clk) disable iff (!rst_n)
        rsp_pending && !rsp_fire |=>
            rsp_pending && $stable(grant_m1_q) && $stable(sel_q) && $stable(rsp_rdata));

endmodule

`default_nettype wire

// ==== soc_io_pkg.sv ====
`default_nettype none

// **********************************************************************
// board-side constants
// **********************************************************************

package soc_io_pkg;

    // one colour channel of the hdmi stream
    localparam int PIX_W = 8;

    // key must read low this long before it counts as a press
    localparam int DEBOUNCE_CYCLES = 16;

    // activity output flips after BLINK_COUNT+1 retire strobes
    localparam int BLINK_COUNT = 7;

    // reset release and soft reset length
    localparam int RST_SYNC_STAGES = 2;
    localparam int RST_HOLD_CYCLES = 4;

endpackage

`default_nettype wire

// ==== soc_bus_pkg.sv ====
`default_nettype none

// **********************************************************************
// icb fabric definitions
// **********************************************************************

package soc_bus_pkg;

    // bus widths
    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int MASK_W = DATA_W / 8;

    // address map, top nibble selects the region
    localparam int REGION_MSB = 31;
    localparam int REGION_LSB = 28;

    localparam logic [REGION_MSB-REGION_LSB:0] SRAM_REGION = 1;

    // on-chip sram, word addressed
    localparam int SRAM_DEPTH = 256;
    localparam int SRAM_AW    = $clog2(SRAM_DEPTH);

    // target of an accepted command
    typedef enum logic {
        SEL_SRAM = 1'b0,
        SEL_ERR  = 1'b1
    } slave_sel_t;

endpackage

`default_nettype wire
